//--- smc_watch_top.f
hdl/smc_pkg.sv
hdl/store_check_if.sv
hdl/watch_slot.sv
hdl/watch_buffer.sv
hdl/smc_watch_top.sv
tb/smc_watch_properties.sv
tb/tb_smc_watch.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_smc_watch
FILELIST  := smc_watch_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the output is kept in a shell variable and searched for the pass line.
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_smc_watch.sv
//====================
// table driven testbench for the code watch buffer.
// runs at the default DEPTH and LANES from smc_pkg.
// written lines keep the top line bit clear and LFSR fillers set it.
// the fill run below assumes DEPTH is above 4.
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_smc_watch import smc_pkg::*; ();

  localparam int DEPTH  = DEPTH_DEF;
  localparam int LANES  = LANES_DEF;
  localparam int MARGIN = 50; // spare cycles for the watchdog.

  localparam line_addr_t LINE_A = 36'h0_1234_5670;
  localparam line_addr_t LINE_B = 36'h0_0abc_def0;
  localparam line_addr_t LINE_C = 36'h2_4680_1350;
  localparam line_addr_t LINE_D = 36'h3_1357_9bd0;
  localparam line_addr_t LINE_E = 36'h0_7777_0040;
  localparam line_addr_t LINE_F = 36'h1_0000_0100; // base of the fill run.
  localparam line_addr_t LINE_X = 36'h5_5555_5550; // write dropped when full.

  typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_CLEAR, OP_CHECK} op_t;

  // one table row holds what to drive and what to expect before the next edge.
  typedef struct packed {
    op_t                    op;
    watch_addr_t            waddr;
    lane_mask_t             en;
    lane_mask_t             odd;
    lane_mask_t             split;
    line_addr_t [LANES-1:0] ae;
    line_addr_t [LANES-1:0] ao;
    lane_mask_t             exp_hit;
    logic                   exp_can;
  } row_t;

  logic             clk;
  logic             rst;
  logic             all_clear;
  logic             wrt_en;
  watch_addr_t      wrt_addr;
  logic [LANES-1:0] st_en;
  logic [LANES-1:0] st_odd;
  logic [LANES-1:0] st_split;
  line_addr_t       st_addr_even [LANES];
  line_addr_t       st_addr_odd  [LANES];
  logic [LANES-1:0] hit;
  logic             wrt_can;

  row_t        tbl [$];
  logic [31:0] lfsr_q;    // filler generator state.
  logic        tbl_ready; // table built and watchdog free to start.

  smc_watch_top #(
    .DEPTH(DEPTH),
    .LANES(LANES)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .all_clear   (all_clear),
    .wrt_en      (wrt_en),
    .wrt_addr    (wrt_addr),
    .st_en       (st_en),
    .st_odd      (st_odd),
    .st_split    (st_split),
    .st_addr_even(st_addr_even),
    .st_addr_odd (st_addr_odd),
    .hit         (hit),
    .wrt_can     (wrt_can)
  );

  always #10 clk = ~clk; // 20 ns period.

  // 32 bit Fibonacci LFSR with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one step per bit taken and the top bit forced high so it never equals a written line.
  task automatic make_filler(output line_addr_t f);
    for (int b = 0; b < LINE_W; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      f[b]   = lfsr_q[0];
    end
    f[LINE_W-1] = 1'b1;
  endtask

  // row with all lanes off and filler addresses everywhere.
  task automatic blank_row(output row_t r, input op_t op);
    line_addr_t f;
    r         = '0;
    r.op      = op;
    r.exp_can = 1'b1;
    for (int l = 0; l < LANES; l++) begin
      make_filler(f);
      r.ae[l] = f;
      make_filler(f);
      r.ao[l] = f;
    end
  endtask

  task automatic enable_lane(inout row_t r, input int l, input logic odd,
                             input logic split);
    r.en[l]    = 1'b1;
    r.odd[l]   = odd;
    r.split[l] = split;
  endtask

  task automatic build_table();
    row_t r;
    // nothing is held after reset so even matching lines miss.
    blank_row(r, OP_CHECK);
    r.en    = '1;
    r.odd   = 4'b0110;
    r.split = 4'b1010;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    for (int l = 0; l < LANES; l++) begin
      enable_lane(r, l, l[0], 1'b1);
      r.ae[l] = LINE_A;
      r.ao[l] = LINE_A;
    end
    tbl.push_back(r);
    // even bank line into slot 0.
    blank_row(r, OP_WRITE);
    r.waddr = {LINE_A, 1'b0};
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b1, 1'b0);
    enable_lane(r, 1, 1'b0, 1'b0);
    enable_lane(r, 2, 1'b0, 1'b1);
    enable_lane(r, 3, 1'b1, 1'b1);
    r.ae[1]   = LINE_A;
    r.exp_hit = 4'b0010;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 1, 1'b1, 1'b0); // odd store skips the even bank.
    r.ae[1] = LINE_A;
    r.ao[1] = LINE_A;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b0, 1'b0);
    r.ae[0]    = LINE_A;
    r.ae[2]    = LINE_A; // lane 2 stays disabled.
    r.split[2] = 1'b1;   // split alone never opens a disabled lane.
    r.exp_hit  = 4'b0001;
    tbl.push_back(r);
    // odd bank line into slot 1.
    blank_row(r, OP_WRITE);
    r.waddr = {LINE_B, 1'b1};
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b0, 1'b1);
    r.ao[0]   = LINE_B;
    r.exp_hit = 4'b0001;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 3, 1'b1, 1'b0);
    r.ae[3] = LINE_B;
    tbl.push_back(r);
    // write slots 2 and 3 and then check all lanes at once.
    blank_row(r, OP_WRITE);
    r.waddr = {LINE_C, 1'b0};
    tbl.push_back(r);
    blank_row(r, OP_WRITE);
    r.waddr = {LINE_D, 1'b1};
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b0, 1'b0);
    enable_lane(r, 1, 1'b1, 1'b0);
    enable_lane(r, 2, 1'b1, 1'b1);
    enable_lane(r, 3, 1'b0, 1'b1);
    r.ae[0]   = LINE_A;
    r.ao[1]   = LINE_B;
    r.ae[2]   = LINE_C;
    r.exp_hit = 4'b0111;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b0, 1'b0);
    enable_lane(r, 1, 1'b0, 1'b0);
    enable_lane(r, 2, 1'b1, 1'b0);
    enable_lane(r, 3, 1'b1, 1'b0);
    r.ae[1]   = LINE_C;
    r.ao[2]   = LINE_A; // line A sits in the even bank.
    r.ao[3]   = LINE_D;
    r.exp_hit = 4'b1010;
    tbl.push_back(r);
    // fill the rest so wrt_can drops after the last write.
    for (int i = 4; i < DEPTH; i++) begin
      blank_row(r, OP_WRITE);
      r.waddr = {LINE_F + line_addr_t'(i), 1'b0};
      tbl.push_back(r);
    end
    blank_row(r, OP_IDLE);
    r.exp_can = 1'b0;
    tbl.push_back(r);
    blank_row(r, OP_WRITE);
    r.waddr   = {LINE_X, 1'b0};
    r.exp_can = 1'b0;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b0, 1'b0);
    enable_lane(r, 1, 1'b0, 1'b0);
    enable_lane(r, 2, 1'b0, 1'b0);
    r.ae[0]   = LINE_X;
    r.ae[1]   = LINE_F + line_addr_t'(DEPTH - 1);
    r.ae[2]   = LINE_A;
    r.exp_hit = 4'b0110;
    r.exp_can = 1'b0;
    tbl.push_back(r);
    // release everything.
    blank_row(r, OP_CLEAR);
    r.exp_can = 1'b0;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b0, 1'b0);
    enable_lane(r, 1, 1'b1, 1'b0);
    enable_lane(r, 2, 1'b0, 1'b0);
    enable_lane(r, 3, 1'b1, 1'b0);
    r.ae[0] = LINE_A;
    r.ao[1] = LINE_B;
    r.ae[2] = LINE_C;
    r.ao[3] = LINE_D;
    tbl.push_back(r);
    // a new write whose own store misses until the next cycle.
    blank_row(r, OP_WRITE);
    r.waddr = {LINE_E, 1'b1};
    enable_lane(r, 2, 1'b1, 1'b0);
    r.ao[2] = LINE_E;
    tbl.push_back(r);
    blank_row(r, OP_CHECK);
    enable_lane(r, 0, 1'b0, 1'b0);
    enable_lane(r, 2, 1'b1, 1'b0);
    r.ae[0]   = LINE_A;
    r.ao[2]   = LINE_E;
    r.exp_hit = 4'b0100;
    tbl.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    all_clear = (r.op == OP_CLEAR);
    wrt_en    = (r.op == OP_WRITE);
    wrt_addr  = r.waddr;
    st_en     = r.en;
    st_odd    = r.odd;
    st_split  = r.split;
    for (int l = 0; l < LANES; l++) begin
      st_addr_even[l] = r.ae[l];
      st_addr_odd[l]  = r.ao[l];
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
      $display("Checks failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // watchdog sized from the table.
  initial begin
    int limit_ns;
    wait (tbl_ready);
    limit_ns = (tbl.size() + MARGIN) * 20;
    #(limit_ns);
    $display("timeout: the table did not finish within %0d ns", limit_ns);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    all_clear = 1'b0;
    wrt_en    = 1'b0;
    wrt_addr  = '0;
    st_en     = '0;
    st_odd    = '0;
    st_split  = '0;
    for (int l = 0; l < LANES; l++) begin
      st_addr_even[l] = '0;
      st_addr_odd[l]  = '0;
    end
    lfsr_q    = 32'd74291;
    tbl_ready = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < tbl.size(); i++) begin
      apply_row(tbl[i]);
      #16; // just before the next rising edge.
      check_value("hit", 64'(tbl[i].exp_hit), 64'(hit));
      check_value("wrt_can", 64'(tbl[i].exp_can), 64'(wrt_can));
      @(posedge clk);
      #2;
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/smc_watch_properties.sv
//====================
// allocation and hit rules of watch_buffer.
// bound into every watch_buffer instance.
// all checks are off while rst is high.
//====================
`timescale 1ns/1ps
`default_nettype none

module smc_watch_properties import smc_pkg::*; #(
  parameter int DEPTH = DEPTH_DEF,
  parameter int LANES = LANES_DEF
) (
  input logic             clk,
  input logic             rst,
  input logic             all_clear,
  input logic             wrt_can,
  input logic [DEPTH-1:0] load_vec, // steered write strobes.
  input logic [LANES-1:0] en,       // lane enables from the bundle.
  input logic [LANES-1:0] hit
);

  // write strobe reaches one slot at most.
  a_one_load: assert property (@(posedge clk) disable iff (rst)
    $onehot0(load_vec))
    else $error("more than one slot loaded in the same cycle");

  // full buffer drops the write.
  a_no_load_full: assert property (@(posedge clk) disable iff (rst)
    !wrt_can |-> (load_vec == '0))
    else $error("a slot loaded while wrt_can was low");

  a_hit_needs_en: assert property (@(posedge clk) disable iff (rst)
    (hit & ~en) == '0)
    else $error("hit raised on a disabled lane");

  // every slot is free one cycle after the pulse.
  a_can_after_clear: assert property (@(posedge clk) disable iff (rst)
    all_clear |=> wrt_can)
    else $error("wrt_can low in the cycle after all_clear");

endmodule

bind watch_buffer smc_watch_properties #(
  .DEPTH(DEPTH),
  .LANES(LANES)
) u_props (
  .clk      (clk),
  .rst      (rst),
  .all_clear(all_clear),
  .wrt_can  (wrt_can),
  .load_vec (load_vec),
  .en       (chk.en),
  .hit      (hit)
);

`default_nettype wire

//--- hdl/smc_watch_top.sv
//====================
// code watch buffer top with plain lane ports.
// store to hit is combinational, a write shows one cycle later.
// the writer must hold off while wrt_can is low.
//====================
`timescale 1ns/1ps
`default_nettype none

module smc_watch_top import smc_pkg::*; #(
  parameter int DEPTH = DEPTH_DEF,
  parameter int LANES = LANES_DEF
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             all_clear,    // frees every slot.
  input  logic             wrt_en,       // one cycle write strobe.
  input  watch_addr_t      wrt_addr,     // fetched line plus bank bit.
  input  logic [LANES-1:0] st_en,
  input  logic [LANES-1:0] st_odd,
  input  logic [LANES-1:0] st_split,
  input  line_addr_t       st_addr_even [LANES],
  input  line_addr_t       st_addr_odd  [LANES],
  output logic [LANES-1:0] hit,          // store overwrote watched code.
  output logic             wrt_can       // a slot is free.
);

  // sizes below one make no sense for the slot array or the lanes.
  if (DEPTH < 1) begin : g_bad_depth
    $error("DEPTH must be at least 1");
  end
  if (LANES < 1) begin : g_bad_lanes
    $error("LANES must be at least 1");
  end

  store_check_if #(
    .LANES(LANES)
  ) chk_if ();

  // plain ports onto the lane bundle.
  assign chk_if.en        = st_en;
  assign chk_if.odd       = st_odd;
  assign chk_if.split     = st_split;
  assign chk_if.addr_even = st_addr_even;
  assign chk_if.addr_odd  = st_addr_odd;

  watch_buffer #(
    .DEPTH(DEPTH),
    .LANES(LANES)
  ) u_buffer (
    .clk      (clk),
    .rst      (rst),
    .all_clear(all_clear),
    .wrt_en   (wrt_en),
    .wrt_addr (wrt_addr),
    .chk      (chk_if.check),
    .hit      (hit),
    .wrt_can  (wrt_can)
  );

endmodule

`default_nettype wire

//--- hdl/watch_buffer.sv
//====================
// array of watch slots with lowest free allocation.
// a write while wrt_can is low is dropped.
// hit is combinational from the store lanes.
//====================
`timescale 1ns/1ps
`default_nettype none

module watch_buffer import smc_pkg::*; #(
  parameter int DEPTH = DEPTH_DEF,
  parameter int LANES = LANES_DEF
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             all_clear,
  input  logic             wrt_en,
  input  watch_addr_t      wrt_addr,
  store_check_if.check     chk,
  output logic [LANES-1:0] hit,
  output logic             wrt_can
);

  logic [DEPTH-1:0] free_vec;   // per slot free flags.
  logic [DEPTH-1:0] first_free; // one-hot lowest free slot.
  logic [DEPTH-1:0] load_vec;   // steered write strobes.
  logic             found;      // some slot is free.
  logic [LANES-1:0] slot_hit [DEPTH];

  // priority search from slot 0 upward.
  always_comb begin
    first_free = '0;
    found      = 1'b0;
    for (int s = 0; s < DEPTH; s++) begin
      if (free_vec[s] && !found) begin
        first_free[s] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  // strobe goes to one slot at most, none when full.
  assign load_vec = {DEPTH{wrt_en}} & first_free;

  // back pressure toward the fetch side.
  assign wrt_can = found;

  for (genvar s = 0; s < DEPTH; s++) begin : g_slot
    watch_slot #(
      .LANES(LANES)
    ) u_slot (
      .clk      (clk),
      .rst      (rst),
      .all_clear(all_clear),
      .load     (load_vec[s]),
      .wrt_addr (wrt_addr),
      .chk      (chk),
      .free     (free_vec[s]),
      .slot_hit (slot_hit[s])
    );
  end

  // per lane OR over all slots.
  always_comb begin
    hit = '0;
    for (int s = 0; s < DEPTH; s++) begin
      hit = hit | slot_hit[s];
    end
  end

endmodule

`default_nettype wire

//--- hdl/watch_slot.sv
//====================
// one watch slot: a held code address and an occupied flag.
// all_clear beats load in the same cycle.
// a free slot never reports a hit.
//====================
`timescale 1ns/1ps
`default_nettype none

module watch_slot import smc_pkg::*; #(
  parameter int LANES = LANES_DEF
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             all_clear,
  input  logic             load,
  input  watch_addr_t      wrt_addr,
  store_check_if.check     chk,
  output logic             free,
  output logic [LANES-1:0] slot_hit
);

  watch_addr_t addr_q;   // captured fetch address.
  logic        occupied; // slot holds a live line.
  line_addr_t  line_q;   // line part of the held address.
  logic        bank_q;   // bank part of the held address.

  assign line_q = addr_q[LINE_W:1];
  assign bank_q = addr_q[0];

  // occupied flag, cleared by reset or by the all-clear pulse.
  always_ff @(posedge clk) begin
    if (rst) begin
      occupied <= 1'b0;
    end else if (all_clear) begin
      occupied <= 1'b0;  // release wins over a write.
    end else if (load) begin
      occupied <= 1'b1;
    end
  end

  // address register, only written when this slot is steered.
  always_ff @(posedge clk) begin
    if (load) begin
      addr_q <= wrt_addr;
    end
  end

  assign free = ~occupied;

  // compare every lane against the held line.
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic even_sel; // store touches the even bank.
    logic odd_sel;  // store touches the odd bank.
    logic even_hit;
    logic odd_hit;

    assign even_sel = ~chk.odd[l] | chk.split[l];
    assign odd_sel  = chk.odd[l] | chk.split[l];

    // even slot compares the even address, odd slot the odd one.
    assign even_hit = ~bank_q & even_sel & (chk.addr_even[l] == line_q);
    assign odd_hit  = bank_q & odd_sel & (chk.addr_odd[l] == line_q);

    assign slot_hit[l] = chk.en[l] & occupied & (even_hit | odd_hit);
  end

endmodule

`default_nettype wire

//--- hdl/store_check_if.sv
//====================
// store lane bundle, one entry per lane in every field.
// levels valid within a cycle, no handshake.
//====================
`timescale 1ns/1ps
`default_nettype none

interface store_check_if import smc_pkg::*; #(
  parameter int LANES = LANES_DEF
);

  logic [LANES-1:0] en;        // lane holds a valid store.
  line_addr_t       addr_even [LANES]; // even bank line address.
  line_addr_t       addr_odd  [LANES]; // odd bank line address.
  logic [LANES-1:0] odd;       // store starts in the odd bank.
  logic [LANES-1:0] split;     // store also covers the other bank.

  // driven from the top level ports.
  modport source (
    output en, addr_even, addr_odd, odd, split
  );

  // read by the buffer and by every slot.
  modport check (
    input en, addr_even, addr_odd, odd, split
  );

endinterface

`default_nettype wire

//--- hdl/smc_pkg.sv
//====================
// shared types and default sizes for the code watch buffer.
// a watch address is a line address with the bank bit at bit 0.
// lane_mask_t matches the default lane count only.
//====================
`default_nettype none

package smc_pkg;

  localparam int LINE_W    = 36; // line address bits, bank bit excluded.
  localparam int LANES_DEF = 4;  // default store lanes checked per cycle.
  localparam int DEPTH_DEF = 8;  // default watch slots.

  // line address of a fetched code line or of one bank of a store.
  typedef logic [LINE_W-1:0] line_addr_t;

  // fetched code address: {line, bank}, bank 0 is even, 1 is odd.
  typedef logic [LINE_W:0] watch_addr_t;

  // one bit per store lane at the default lane count.
  typedef logic [LANES_DEF-1:0] lane_mask_t;

endpackage

`default_nettype wire
